/* sim.f */
roc_pkg.sv
roc_mem_if.sv
roc_route.sv
roc_lookup.sv
roc_mem_port.sv
roc_top.sv
tb_roc_mem.sv
tb_roc.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_roc -f sim.f -o tb_roc \
  && ./obj_dir/tb_roc > sim.log 2>&1 \
  || echo "Simulation did not run to completion" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

/* tb_roc.sv */
// Testbench top: clock, reset, random reads and flushes, cache model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_roc;

  localparam int unsigned LineCount    = 8;
  localparam int unsigned WordsPerLine = 4;
  localparam int unsigned LineBytes    = WordsPerLine * 4;
  localparam int          NumReads     = 400;
  localparam int          Timeout      = 100;
  localparam logic [31:0] WinBase      = 32'h0000_1000;
  localparam logic [31:0] WinLimit     = 32'h0000_1400;

  logic        clk_i;
  logic        rst_ni;
  logic        enable_i;
  logic        flush_valid_i;
  logic        flush_ready_o;
  logic [31:0] cache_base_i;
  logic [31:0] cache_limit_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [31:0] req_addr_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  logic [31:0] rsp_data_o;
  logic        mem_req_valid_o;
  logic        mem_req_ready_i;
  logic [31:0] mem_req_addr_o;
  logic        mem_rsp_valid_i;
  logic [31:0] mem_rsp_data_i;

  // Reference model of the cache contents
  logic        model_valid [LineCount];
  logic [31:0] model_tag   [LineCount];
  logic [31:0] mem_seen    [$];
  logic [31:0] mem_expect  [$];

  integer seed;
  int     error_count;
  int     timeout_count;
  int     hit_count;
  int     miss_count;
  int     bypass_count;
  int     flush_count;
  bit     timed_out;

  roc_top #(
    .LineCount    (LineCount),
    .WordsPerLine (WordsPerLine)
  ) roc_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .enable_i        (enable_i),
    .flush_valid_i   (flush_valid_i),
    .flush_ready_o   (flush_ready_o),
    .cache_base_i    (cache_base_i),
    .cache_limit_i   (cache_limit_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_data_o      (rsp_data_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i)
  );

  tb_roc_mem #(
    .Seed (32'h69d6_cd1d)
  ) mem_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_o (mem_req_ready_i),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_rsp_valid_o (mem_rsp_valid_i),
    .mem_rsp_data_o  (mem_rsp_data_i)
  );

  function automatic logic [31:0] word_data(input logic [31:0] byte_addr);
    return {2'b00, byte_addr[31:2]} ^ 32'hA5A5_0000;
  endfunction

  function automatic int unsigned line_index(input logic [31:0] a);
    return int'((a / LineBytes) % LineCount);
  endfunction

  function automatic logic [31:0] line_tag(input logic [31:0] a);
    return a / (LineBytes * LineCount);
  endfunction

  task automatic fail_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
    error_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timeout while waiting for %s at time %0t", what, $time);
    timeout_count++;
    timed_out = 1'b1;
  endtask

  // ---------------------------------------------------------------------
  // Memory port monitor, sampled between falling and rising edge
  // ---------------------------------------------------------------------
  always begin
    @(negedge clk_i);
    #1;
    if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
      mem_seen.push_back(mem_req_addr_o);
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Half the reads land in a small part of the window, the rest mostly outside
  task automatic pick_read(output logic [31:0] addr, output logic en);
    logic [31:0] r;
    r  = $random(seed);
    en = (r[2:0] != 3'd0);
    r  = $random(seed);
    case (r[2:0])
      3'd4: addr = WinLimit;
      3'd5: addr = WinBase - 32'd4;
      3'd6, 3'd7: begin
        addr = $random(seed);
        addr = {addr[31:2], 2'b00};
      end
      default: addr = WinBase + ((r >> 8) % 32'd96) * 32'd4;
    endcase
  endtask

  task automatic do_flush();
    int cycles;
    @(negedge clk_i);
    flush_valid_i = 1'b1;
    #1;
    cycles = 0;
    while (!flush_ready_o && cycles < Timeout) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!flush_ready_o) begin
      report_timeout("flush acceptance");
      return;
    end
    @(negedge clk_i);
    flush_valid_i = 1'b0;
    for (int i = 0; i < LineCount; i++) begin
      model_valid[i] = 1'b0;
    end
    flush_count++;
  endtask

  task automatic do_read(input logic [31:0] addr, input logic en);
    logic        cacheable;
    int unsigned idx;
    logic [31:0] line_base;
    logic [31:0] expect_data;
    logic [31:0] held_data;
    logic [31:0] r;
    logic        held;
    logic        done;
    int          cycles;

    // Expected memory traffic from the model
    cacheable   = en && (addr >= WinBase) && (addr < WinLimit);
    expect_data = word_data(addr);
    idx         = line_index(addr);
    line_base   = addr & ~(LineBytes - 1);
    if (!cacheable) begin
      mem_expect.push_back(addr);
      bypass_count++;
    end else if (model_valid[idx] && model_tag[idx] == line_tag(addr)) begin
      hit_count++;
    end else begin
      for (int w = 0; w < WordsPerLine; w++) begin
        mem_expect.push_back(line_base + 32'(w * 4));
      end
      model_valid[idx] = 1'b1;
      model_tag[idx]   = line_tag(addr);
      miss_count++;
    end

    @(negedge clk_i);
    enable_i    = en;
    req_addr_i  = addr;
    req_valid_i = 1'b1;
    #1;
    cycles = 0;
    while (!req_ready_o && cycles < Timeout) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!req_ready_o) begin
      report_timeout("request acceptance");
      return;
    end

    // Response phase with random back-pressure
    held   = 1'b0;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < Timeout) begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
      r           = $random(seed);
      rsp_ready_i = (r[1:0] != 2'b00);
      #1;
      cycles++;
      if (req_ready_o) begin
        $display("FAILED at time %0t: req_ready_o high before response handshake", $time);
        error_count++;
      end
      if (held && !rsp_valid_o) begin
        $display("FAILED at time %0t: rsp_valid_o dropped under back-pressure", $time);
        error_count++;
      end
      if (held && rsp_valid_o && rsp_data_o !== held_data) begin
        fail_value("rsp_data_o changed under back-pressure", rsp_data_o, held_data);
      end
      if (rsp_valid_o && !held && rsp_data_o !== expect_data) begin
        fail_value("read data", rsp_data_o, expect_data);
      end
      if (rsp_valid_o && rsp_ready_i) begin
        done = 1'b1;
      end else if (rsp_valid_o) begin
        held      = 1'b1;
        held_data = rsp_data_o;
      end
    end
    if (!done) begin
      report_timeout("read response");
      return;
    end

    @(negedge clk_i);
    rsp_ready_i = 1'b0;
    if (mem_seen.size() != mem_expect.size()) begin
      $display("FAILED at time %0t: read of %h made %0d memory requests, expected %0d",
               $time, addr, mem_seen.size(), mem_expect.size());
      error_count++;
    end else begin
      foreach (mem_seen[k]) begin
        if (mem_seen[k] !== mem_expect[k]) begin
          fail_value("memory request address", mem_seen[k], mem_expect[k]);
        end
      end
    end
    mem_seen.delete();
    mem_expect.delete();
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] r;
    logic        en;

    seed          = 32'h69d6_cd1d;
    error_count   = 0;
    timeout_count = 0;
    hit_count     = 0;
    miss_count    = 0;
    bypass_count  = 0;
    flush_count   = 0;
    timed_out     = 1'b0;
    rst_ni        = 1'b0;
    enable_i      = 1'b1;
    flush_valid_i = 1'b0;
    cache_base_i  = WinBase;
    cache_limit_i = WinLimit;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    rsp_ready_i   = 1'b0;
    for (int i = 0; i < LineCount; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // Idle state straight after reset
    if (rsp_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0) begin
      $display("FAILED at time %0t: valid output high after reset", $time);
      error_count++;
    end
    if (req_ready_o !== 1'b1 || flush_ready_o !== 1'b1) begin
      $display("FAILED at time %0t: ready output low after reset", $time);
      error_count++;
    end

    for (int n = 0; n < NumReads && !timed_out; n++) begin
      r = $random(seed);
      if (r[3:0] == 4'd0) begin
        do_flush();
      end
      if (!timed_out) begin
        pick_read(addr, en);
        do_read(addr, en);
      end
    end

    $display("Errors: %0d value, %0d timeout (hits %0d, misses %0d, bypass %0d, flushes %0d)",
             error_count, timeout_count, hit_count, miss_count, bypass_count, flush_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_roc_mem.sv */
// Backing memory responder with random stall, random latency and address-derived data
`timescale 1ns/1ps
`default_nettype none

module tb_roc_mem #(
  parameter logic [31:0] Seed = 32'h0000_0001
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        mem_req_valid_i,
  output logic        mem_req_ready_o,
  input  logic [31:0] mem_req_addr_i,
  output logic        mem_rsp_valid_o,
  output logic [31:0] mem_rsp_data_o
);

  integer      seed;
  logic [31:0] rnd;
  logic [31:0] addr;
  int          stall;
  int          lat;

  // Word address XOR a fixed pattern
  function automatic logic [31:0] word_data(input logic [31:0] byte_addr);
    return {2'b00, byte_addr[31:2]} ^ 32'hA5A5_0000;
  endfunction

  initial begin
    seed            = Seed;
    mem_req_ready_o = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_data_o  = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_valid_i) begin
        // Hold ready low for 0 to 3 cycles
        rnd   = $random(seed);
        stall = int'(rnd[1:0]);
        repeat (stall) @(negedge clk_i);
        mem_req_ready_o = 1'b1;
        addr            = mem_req_addr_i;
        @(negedge clk_i);
        mem_req_ready_o = 1'b0;
        // Answer 1 to 4 cycles after the handshake
        rnd = $random(seed);
        lat = int'(rnd[1:0]) + 1;
        repeat (lat - 1) @(negedge clk_i);
        mem_rsp_valid_o = 1'b1;
        mem_rsp_data_o  = word_data(addr);
        @(negedge clk_i);
        mem_rsp_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* roc_top.sv */
// Read-only cache top level: router, lookup, memory port and two memory channels
`timescale 1ns/1ps
`default_nettype none

module roc_top #(
  parameter int unsigned LineCount    = 8,
  parameter int unsigned WordsPerLine = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       flush_valid_i,
  output logic                       flush_ready_o,
  input  logic [roc_pkg::ADDR_W-1:0] cache_base_i,
  input  logic [roc_pkg::ADDR_W-1:0] cache_limit_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [roc_pkg::ADDR_W-1:0] req_addr_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [roc_pkg::DATA_W-1:0] rsp_data_o,
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output logic [roc_pkg::ADDR_W-1:0] mem_req_addr_o,
  input  logic                       mem_rsp_valid_i,
  input  logic [roc_pkg::DATA_W-1:0] mem_rsp_data_i
);

  // Router to lookup
  logic                       lk_req_valid;
  logic                       lk_req_ready;
  logic [roc_pkg::ADDR_W-1:0] lk_req_addr;
  logic                       lk_rsp_valid;
  logic                       lk_rsp_ready;
  logic [roc_pkg::DATA_W-1:0] lk_rsp_data;

  roc_mem_if refill_mem ();
  roc_mem_if bypass_mem ();

  roc_route u_route (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .cache_base_i   (cache_base_i),
    .cache_limit_i  (cache_limit_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_addr_i     (req_addr_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_data_o     (rsp_data_o),
    .lk_req_valid_o (lk_req_valid),
    .lk_req_ready_i (lk_req_ready),
    .lk_req_addr_o  (lk_req_addr),
    .lk_rsp_valid_i (lk_rsp_valid),
    .lk_rsp_ready_o (lk_rsp_ready),
    .lk_rsp_data_i  (lk_rsp_data),
    .bypass_mem     (bypass_mem)
  );

  roc_lookup #(
    .LineCount    (LineCount),
    .WordsPerLine (WordsPerLine)
  ) u_lookup (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .req_valid_i   (lk_req_valid),
    .req_ready_o   (lk_req_ready),
    .req_addr_i    (lk_req_addr),
    .rsp_valid_o   (lk_rsp_valid),
    .rsp_ready_i   (lk_rsp_ready),
    .rsp_data_o    (lk_rsp_data),
    .refill_mem    (refill_mem)
  );

  roc_mem_port u_mem_port (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .refill_mem      (refill_mem),
    .bypass_mem      (bypass_mem),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i)
  );

endmodule

`default_nettype wire

/* roc_mem_port.sv */
// Memory port arbiter with refill over bypass priority and response steering by owner
`timescale 1ns/1ps
`default_nettype none

module roc_mem_port (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  roc_mem_if.server                  refill_mem,
  roc_mem_if.server                  bypass_mem,
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output logic [roc_pkg::ADDR_W-1:0] mem_req_addr_o,
  input  logic                       mem_rsp_valid_i,
  input  logic [roc_pkg::DATA_W-1:0] mem_rsp_data_i
);

  roc_pkg::owner_e owner_q;
  roc_pkg::owner_e grant;
  logic            mem_req_fire;

  // ---------------------------------------------------------------------
  // Grant only while no request is outstanding
  // ---------------------------------------------------------------------
  always_comb begin
    grant = roc_pkg::OWN_NONE;
    if (owner_q == roc_pkg::OWN_NONE) begin
      if (refill_mem.req_valid) begin
        grant = roc_pkg::OWN_REFILL;
      end else if (bypass_mem.req_valid) begin
        grant = roc_pkg::OWN_BYPASS;
      end
    end
  end

  assign mem_req_valid_o = (grant != roc_pkg::OWN_NONE);
  assign mem_req_addr_o  = (grant == roc_pkg::OWN_BYPASS) ? bypass_mem.req_addr
                                                          : refill_mem.req_addr;
  assign mem_req_fire    = mem_req_valid_o && mem_req_ready_i;

  assign refill_mem.req_ready = (grant == roc_pkg::OWN_REFILL) && mem_req_ready_i;
  assign bypass_mem.req_ready = (grant == roc_pkg::OWN_BYPASS) && mem_req_ready_i;

  // ---------------------------------------------------------------------
  // Response steering
  // ---------------------------------------------------------------------
  assign refill_mem.rsp_valid = mem_rsp_valid_i && (owner_q == roc_pkg::OWN_REFILL);
  assign bypass_mem.rsp_valid = mem_rsp_valid_i && (owner_q == roc_pkg::OWN_BYPASS);
  assign refill_mem.rsp_data  = mem_rsp_data_i;
  assign bypass_mem.rsp_data  = mem_rsp_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= roc_pkg::OWN_NONE;
    end else if (mem_req_fire) begin
      owner_q <= grant;
    end else if (mem_rsp_valid_i) begin
      owner_q <= roc_pkg::OWN_NONE;
    end
  end

  // A request towards memory holds its address until it is taken
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o));

  // Memory must not answer without an outstanding request
  a_rsp_has_owner : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_valid_i |-> owner_q != roc_pkg::OWN_NONE);

endmodule

`default_nettype wire

/* roc_lookup.sv */
// Direct-mapped tag/valid/data arrays, hit check, flush and line refill FSM
`timescale 1ns/1ps
`default_nettype none

module roc_lookup #(
  parameter int unsigned LineCount    = 8,
  parameter int unsigned WordsPerLine = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_valid_i,
  output logic                       flush_ready_o,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [roc_pkg::ADDR_W-1:0] req_addr_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [roc_pkg::DATA_W-1:0] rsp_data_o,
  roc_mem_if.client                  refill_mem
);

  // Address split into tag, index, word offset and byte offset
  localparam int unsigned OFF_W    = $clog2(WordsPerLine);
  localparam int unsigned IDX_W    = $clog2(LineCount);
  localparam int unsigned LINE_LSB = OFF_W + roc_pkg::BYTE_OFF_W;
  localparam int unsigned TAG_W    = roc_pkg::ADDR_W - IDX_W - LINE_LSB;

  if (LineCount < 2 || WordsPerLine < 2 ||
      (1 << IDX_W) != LineCount || (1 << OFF_W) != WordsPerLine) begin : gen_param_check
    $error("roc_lookup: LineCount and WordsPerLine must be powers of two, at least 2");
  end

  roc_pkg::lookup_state_e     state_q;
  roc_pkg::lookup_state_e     state_d;
  logic [roc_pkg::ADDR_W-1:0] addr_q;
  logic [OFF_W-1:0]           cnt_q;
  logic                       pend_q;

  logic [LineCount-1:0]       valid_q;
  logic [TAG_W-1:0]           tag_q  [LineCount];
  logic [roc_pkg::DATA_W-1:0] data_q [LineCount][WordsPerLine];

  logic [TAG_W-1:0]           line_tag;
  logic [IDX_W-1:0]           line_idx;
  logic [OFF_W-1:0]           word_off;
  logic                       hit;
  logic                       req_fire;
  logic                       flush_fire;
  logic                       refill_done;

  assign line_tag = addr_q[roc_pkg::ADDR_W-1 -: TAG_W];
  assign line_idx = addr_q[LINE_LSB +: IDX_W];
  assign word_off = addr_q[roc_pkg::BYTE_OFF_W +: OFF_W];

  assign hit = valid_q[line_idx] && (tag_q[line_idx] == line_tag);

  // A pending flush blocks new requests
  assign flush_ready_o = (state_q == roc_pkg::LK_IDLE);
  assign req_ready_o   = (state_q == roc_pkg::LK_IDLE) && !flush_valid_i;
  assign req_fire      = req_valid_i && req_ready_o;
  assign flush_fire    = flush_valid_i && flush_ready_o;

  assign rsp_valid_o = (state_q == roc_pkg::LK_RESPOND);
  assign rsp_data_o  = data_q[line_idx][word_off];

  // ---------------------------------------------------------------------
  // Refill requests go out one word at a time from the line base upward
  // ---------------------------------------------------------------------
  assign refill_mem.req_valid = (state_q == roc_pkg::LK_REFILL) && !pend_q;
  assign refill_mem.req_addr  = roc_pkg::align_down(addr_q, LINE_LSB)
                              | (roc_pkg::ADDR_W'(cnt_q) << roc_pkg::BYTE_OFF_W);

  assign refill_done = refill_mem.rsp_valid && (cnt_q == OFF_W'(WordsPerLine - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      roc_pkg::LK_IDLE: begin
        if (req_fire) begin
          state_d = roc_pkg::LK_CHECK;
        end
      end
      roc_pkg::LK_CHECK: begin
        state_d = hit ? roc_pkg::LK_RESPOND : roc_pkg::LK_REFILL;
      end
      roc_pkg::LK_REFILL: begin
        if (refill_done) begin
          state_d = roc_pkg::LK_RESPOND;
        end
      end
      roc_pkg::LK_RESPOND: begin
        if (rsp_ready_i) begin
          state_d = roc_pkg::LK_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= roc_pkg::LK_IDLE;
      valid_q <= '0;
      cnt_q   <= '0;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (flush_fire) begin
        valid_q <= '0;
      end
      // Line is invalid while it is being overwritten
      if (state_q == roc_pkg::LK_CHECK && !hit) begin
        valid_q[line_idx] <= 1'b0;
        cnt_q             <= '0;
        pend_q            <= 1'b0;
      end
      if (refill_mem.req_valid && refill_mem.req_ready) begin
        pend_q <= 1'b1;
      end
      if (refill_mem.rsp_valid) begin
        pend_q <= 1'b0;
        cnt_q  <= cnt_q + 1'b1;
      end
      if (refill_done) begin
        valid_q[line_idx] <= 1'b1;
      end
    end
  end

  // Arrays and captured address
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      addr_q <= req_addr_i;
    end
    if (refill_mem.rsp_valid) begin
      data_q[line_idx][cnt_q] <= refill_mem.rsp_data;
    end
    if (refill_done) begin
      tag_q[line_idx] <= line_tag;
    end
  end

  a_rsp_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o));

  // Refill responses arrive only while refilling
  a_refill_in_state : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != roc_pkg::LK_REFILL |-> !refill_mem.rsp_valid);

endmodule

`default_nettype wire

/* roc_route.sv */
// Request router with window decode, bypass issue and response merge
`timescale 1ns/1ps
`default_nettype none

module roc_route (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic [roc_pkg::ADDR_W-1:0] cache_base_i,
  input  logic [roc_pkg::ADDR_W-1:0] cache_limit_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [roc_pkg::ADDR_W-1:0] req_addr_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [roc_pkg::DATA_W-1:0] rsp_data_o,
  output logic                       lk_req_valid_o,
  input  logic                       lk_req_ready_i,
  output logic [roc_pkg::ADDR_W-1:0] lk_req_addr_o,
  input  logic                       lk_rsp_valid_i,
  output logic                       lk_rsp_ready_o,
  input  logic [roc_pkg::DATA_W-1:0] lk_rsp_data_i,
  roc_mem_if.client                  bypass_mem
);

  logic                       cacheable;
  logic                       req_fire;
  logic                       rsp_fire;
  logic                       busy_q;
  roc_pkg::route_e            route_q;
  logic                       byp_req_q;
  logic [roc_pkg::ADDR_W-1:0] byp_addr_q;
  logic                       byp_rsp_valid_q;
  logic [roc_pkg::DATA_W-1:0] byp_data_q;

  // Window includes its base and excludes its limit
  assign cacheable = enable_i && (req_addr_i >= cache_base_i) && (req_addr_i < cache_limit_i);

  // Cached requests are handed over in the same cycle, so the lookup must be ready too
  assign req_ready_o    = !busy_q && (!cacheable || lk_req_ready_i);
  assign req_fire       = req_valid_i && req_ready_o;
  assign lk_req_valid_o = req_valid_i && cacheable && !busy_q;
  assign lk_req_addr_o  = req_addr_i;

  assign bypass_mem.req_valid = byp_req_q;
  assign bypass_mem.req_addr  = byp_addr_q;

  // ---------------------------------------------------------------------
  // Response merge
  // ---------------------------------------------------------------------
  always_comb begin
    if (route_q == roc_pkg::ROUTE_BYPASS) begin
      rsp_valid_o    = byp_rsp_valid_q;
      rsp_data_o     = byp_data_q;
      lk_rsp_ready_o = 1'b0;
    end else begin
      rsp_valid_o    = lk_rsp_valid_i;
      rsp_data_o     = lk_rsp_data_i;
      lk_rsp_ready_o = rsp_ready_i;
    end
  end

  assign rsp_fire = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q          <= 1'b0;
      route_q         <= roc_pkg::ROUTE_CACHE;
      byp_req_q       <= 1'b0;
      byp_rsp_valid_q <= 1'b0;
    end else begin
      if (req_fire) begin
        busy_q    <= 1'b1;
        route_q   <= cacheable ? roc_pkg::ROUTE_CACHE : roc_pkg::ROUTE_BYPASS;
        byp_req_q <= !cacheable;
      end else if (rsp_fire) begin
        busy_q <= 1'b0;
      end
      if (bypass_mem.req_valid && bypass_mem.req_ready) begin
        byp_req_q <= 1'b0;
      end
      // Hold the bypass word until the requester takes it
      if (bypass_mem.rsp_valid) begin
        byp_rsp_valid_q <= 1'b1;
      end else if (rsp_fire && route_q == roc_pkg::ROUTE_BYPASS) begin
        byp_rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      byp_addr_q <= roc_pkg::align_down(req_addr_i, roc_pkg::BYTE_OFF_W);
    end
    if (bypass_mem.rsp_valid) begin
      byp_data_q <= bypass_mem.rsp_data;
    end
  end

  // A new request is taken only after the last one has fully drained
  a_no_accept_while_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_fire |-> !byp_req_q && !byp_rsp_valid_q && !lk_rsp_valid_i);

endmodule

`default_nettype wire

/* roc_mem_if.sv */
// Single-word read channel towards backing memory, client and server modports
`timescale 1ns/1ps
`default_nettype none

interface roc_mem_if;

  // Request side, address held while req_valid is high
  logic                        req_valid;
  logic                        req_ready;
  logic [roc_pkg::ADDR_W-1:0]  req_addr;

  // Response pulse, no back-pressure
  logic                        rsp_valid;
  logic [roc_pkg::DATA_W-1:0]  rsp_data;

  modport client (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  rsp_valid,
    input  rsp_data
  );

  modport server (
    input  req_valid,
    input  req_addr,
    output req_ready,
    output rsp_valid,
    output rsp_data
  );

endinterface

`default_nettype wire

/* roc_pkg.sv */
// Widths, route/state/owner enums and the address alignment helper
`default_nettype none

package roc_pkg;

  // Bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BYTE_OFF_W = 2;

  // Where the request in flight was sent
  typedef enum logic {
    ROUTE_CACHE,
    ROUTE_BYPASS
  } route_e;

  typedef enum logic [1:0] {
    LK_IDLE,
    LK_CHECK,
    LK_REFILL,
    LK_RESPOND
  } lookup_state_e;

  // Current holder of the backing memory port
  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_REFILL,
    OWN_BYPASS
  } owner_e;

  // Clear all address bits below lsb
  function automatic logic [ADDR_W-1:0] align_down(input logic [ADDR_W-1:0] addr,
                                                   input int unsigned       lsb);
    logic [ADDR_W-1:0] mask;
    mask = {ADDR_W{1'b1}} << lsb;
    return addr & mask;
  endfunction

endpackage

`default_nettype wire
